// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log reports it
set -e
cd "$(dirname "$0")"

verilator --binary -f tb.f --top-module tb_croc_domain -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "TB PASSED" sim.log

// File: sim/tb_croc_domain.sv
// Table-driven testbench of the data-side bus slice.
// Runs SRAM, SoC control, GPIO and error accesses back to back on the manager port.
`default_nettype none
`timescale 1ns/100ps

module tb_croc_domain;

  localparam int BankNumWords = 256;
  localparam int GpioCount    = 16;
  localparam int ResetCycles  = 5;
  localparam int MaxRows      = 48;

  // Values written to the peripherals
  localparam logic [31:0] BootAddrNew = 32'h1000_0080;
  localparam logic [31:0] GpioDirWord = 32'hFFFF_0F0F;
  localparam logic [31:0] GpioOutWord = 32'h1234_8421;
  localparam logic [31:0] GpioPads    = 32'h0000_A5C3;

  logic                 clk_i = 1'b0;
  logic                 arst_n_i;
  logic                 req_i;
  logic                 we_i;
  logic [3:0]           be_i;
  logic [31:0]          addr_i;
  logic [31:0]          wdata_i;
  logic [GpioCount-1:0] gpio_i;
  logic                 gnt_o;
  logic                 rvalid_o;
  logic [31:0]          rdata_o;
  logic                 err_o;
  logic [31:0]          boot_addr_o;
  logic                 fetch_enable_o;
  logic [GpioCount-1:0] gpio_o;
  logic [GpioCount-1:0] gpio_out_en_o;
  logic [GpioCount-1:0] gpio_in_sync_o;

  // Stimulus table with one row per access
  logic                 tbl_we    [MaxRows];
  logic [3:0]           tbl_be    [MaxRows];
  logic [31:0]          tbl_addr  [MaxRows];
  logic [31:0]          tbl_wdata [MaxRows];
  logic [GpioCount-1:0] tbl_gpio  [MaxRows];
  logic [31:0]          tbl_rdata [MaxRows];
  logic                 tbl_err   [MaxRows];
  logic                 tbl_chk   [MaxRows];

  logic [31:0]          sram_model [BankNumWords];
  logic [GpioCount-1:0] cur_gpio;
  integer               seed = 39986;
  int                   n_rows = 0;
  int                   errors = 0;
  int                   cycles = 0;

  always #2 clk_i = ~clk_i;

  croc_domain #(
    .BankNumWords ( BankNumWords ),
    .GpioCount    ( GpioCount    )
  ) i_croc_domain (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .req_i          ( req_i          ),
    .we_i           ( we_i           ),
    .be_i           ( be_i           ),
    .addr_i         ( addr_i         ),
    .wdata_i        ( wdata_i        ),
    .gpio_i         ( gpio_i         ),
    .gnt_o          ( gnt_o          ),
    .rvalid_o       ( rvalid_o       ),
    .rdata_o        ( rdata_o        ),
    .err_o          ( err_o          ),
    .boot_addr_o    ( boot_addr_o    ),
    .fetch_enable_o ( fetch_enable_o ),
    .gpio_o         ( gpio_o         ),
    .gpio_out_en_o  ( gpio_out_en_o  ),
    .gpio_in_sync_o ( gpio_in_sync_o )
  );

  // Limit follows the table length
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= n_rows * 2 + ResetCycles + 20) begin
      $display("Timeout after %0d cycles, the test did not reach its end", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // ------------------------------------------------------------
  // Table construction
  // ------------------------------------------------------------
  task automatic add_row(input logic we, input logic [3:0] be, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [31:0] rdata,
                         input logic err, input logic chk);
    tbl_we[n_rows]    = we;
    tbl_be[n_rows]    = be;
    tbl_addr[n_rows]  = addr;
    tbl_wdata[n_rows] = wdata;
    tbl_gpio[n_rows]  = cur_gpio;
    tbl_rdata[n_rows] = rdata;
    tbl_err[n_rows]   = err;
    tbl_chk[n_rows]   = chk;
    n_rows++;
  endtask

  // Model keeps only the enabled byte lanes
  task automatic sram_write(input int idx, input logic [3:0] be);
    logic [31:0] data;
    data = $random(seed);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        sram_model[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
    add_row(1'b1, be, 32'h1000_0000 + 32'(idx * 4), data, 32'h0, 1'b0, 1'b0);
  endtask

  task automatic sram_read(input int idx);
    add_row(1'b0, 4'hF, 32'h1000_0000 + 32'(idx * 4), 32'h0, sram_model[idx], 1'b0, 1'b1);
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    add_row(1'b1, 4'hF, addr, data, 32'h0, 1'b0, 1'b0);
  endtask

  task automatic reg_read(input logic [31:0] addr, input logic [31:0] exp);
    add_row(1'b0, 4'hF, addr, 32'h0, exp, 1'b0, 1'b1);
  endtask

  // Error subordinate answers reads and writes alike
  task automatic bad_access(input logic we, input logic [31:0] addr);
    add_row(we, 4'hF, addr, 32'hDEAD_0000 ^ addr, 32'hBADC_AB1E, 1'b1, 1'b1);
  endtask

  task automatic build_table();
    cur_gpio = '0;
    sram_write(0, 4'b1111);
    sram_write(1, 4'b1111);
    sram_write(2, 4'b1111);
    sram_write(255, 4'b1111);
    sram_read(0);
    sram_read(1);
    sram_read(2);
    sram_read(255);
    // Partial lanes over known words
    sram_write(1, 4'b0011);
    sram_write(2, 4'b1000);
    sram_write(0, 4'b0101);
    sram_read(1);
    sram_read(2);
    sram_read(0);
    sram_write(3, 4'b1111);
    sram_read(3);
    // SoC control
    reg_write(32'h0300_0000, BootAddrNew);
    reg_write(32'h0300_0004, 32'h1);
    reg_read(32'h0300_0000, BootAddrNew);
    reg_read(32'h0300_0004, 32'h1);
    reg_read(32'h0300_001C, 32'h0);
    // GPIO pads stay constant from here on
    cur_gpio = GpioPads[GpioCount-1:0];
    reg_write(32'h0300_5000, GpioDirWord);
    reg_write(32'h0300_5004, GpioOutWord);
    reg_read(32'h0300_5000, 32'(GpioDirWord[GpioCount-1:0]));
    reg_read(32'h0300_5004, 32'(GpioOutWord[GpioCount-1:0]));
    reg_read(32'h0300_5008, 32'(GpioPads[GpioCount-1:0]));
    // Unmapped pages and index past the bank
    bad_access(1'b0, 32'h2000_0000);
    bad_access(1'b1, 32'h0000_0000);
    bad_access(1'b0, 32'h1000_0400);
    bad_access(1'b1, 32'h1000_0FFC);
    bad_access(1'b0, 32'h0300_1000);
    sram_read(255);
  endtask

  task automatic check_response(input int r);
    if (rvalid_o !== 1'b1) begin
      $display("Row %0d got no response one cycle after its request", r);
      errors++;
    end else begin
      check_value($sformatf("err_o row %0d", r), 32'(err_o), 32'(tbl_err[r]));
      if (tbl_chk[r]) begin
        check_value($sformatf("rdata_o row %0d", r), rdata_o, tbl_rdata[r]);
      end
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    build_table();
    arst_n_i <= 1'b0;
    req_i    <= 1'b0;
    we_i     <= 1'b0;
    be_i     <= 4'h0;
    addr_i   <= 32'h0;
    wdata_i  <= 32'h0;
    gpio_i   <= '0;
    repeat (ResetCycles) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_value("rvalid_o", 32'(rvalid_o), 32'h0);
    check_value("err_o", 32'(err_o), 32'h0);
    check_value("boot_addr_o", boot_addr_o, 32'h1000_0000);
    check_value("fetch_enable_o", 32'(fetch_enable_o), 32'h0);
    check_value("gpio_o", 32'(gpio_o), 32'h0);
    check_value("gpio_out_en_o", 32'(gpio_out_en_o), 32'h0);
    check_value("gpio_in_sync_o", 32'(gpio_in_sync_o), 32'h0);

    // One row per cycle with each response checked a cycle later
    for (int i = 0; i <= n_rows; i++) begin
      @(posedge clk_i);
      if (i < n_rows) begin
        req_i   <= 1'b1;
        we_i    <= tbl_we[i];
        be_i    <= tbl_be[i];
        addr_i  <= tbl_addr[i];
        wdata_i <= tbl_wdata[i];
        gpio_i  <= tbl_gpio[i];
      end else begin
        req_i <= 1'b0;
        we_i  <= 1'b0;
      end
      @(negedge clk_i);
      check_value("gnt_o", 32'(gnt_o), 32'(req_i));
      if (i > 0) begin
        check_response(i - 1);
      end
    end

    // No request left and no response due
    @(negedge clk_i);
    check_value("rvalid_o", 32'(rvalid_o), 32'h0);
    check_value("err_o", 32'(err_o), 32'h0);
    check_value("boot_addr_o", boot_addr_o, BootAddrNew);
    check_value("fetch_enable_o", 32'(fetch_enable_o), 32'h1);
    check_value("gpio_out_en_o", 32'(gpio_out_en_o), 32'(GpioDirWord[GpioCount-1:0]));
    check_value("gpio_o", 32'(gpio_o), 32'(GpioOutWord[GpioCount-1:0]));
    check_value("gpio_in_sync_o", 32'(gpio_in_sync_o), 32'(GpioPads[GpioCount-1:0]));

    $display("Checks done over %0d rows, %0d errors", n_rows, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
verilog/croc_bus_pkg.sv
verilog/croc_map_pkg.sv
verilog/croc_addr_decode.sv
verilog/croc_sram_bank.sv
verilog/croc_periph_regs.sv
verilog/croc_rsp_mux.sv
verilog/croc_domain.sv
sim/tb_croc_domain.sv

// File: verilog/croc_addr_decode.sv
// Combinational address decoder of the data bus.
// Picks one target per request and extracts the word index.
`default_nettype none
`timescale 1ns/100ps

module croc_addr_decode #(
  parameter int unsigned BankNumWords = 256
) (
  input  logic                                    req_i,
  input  croc_bus_pkg::croc_addr_u                addr_i,
  output croc_bus_pkg::croc_tgt_e                 tgt_o,
  output logic [croc_bus_pkg::WordIdxWidth-1:0]   word_idx_o,
  output logic                                    sram_req_o,
  output logic                                    soc_req_o,
  output logic                                    gpio_req_o
);

  logic in_bank;
  logic sram_hit;
  logic soc_hit;
  logic gpio_hit;

  assign word_idx_o = addr_i.fields.word_idx;

  // SRAM page is only partly populated
  assign in_bank  = 32'(addr_i.fields.word_idx) < BankNumWords;
  assign sram_hit = (addr_i.fields.page == croc_map_pkg::SramPage) && in_bank;
  assign soc_hit  = addr_i.fields.page == croc_map_pkg::SocCtrlPage;
  assign gpio_hit = addr_i.fields.page == croc_map_pkg::GpioPage;

  always_comb begin
    tgt_o = croc_bus_pkg::TgtError;
    if (sram_hit) begin
      tgt_o = croc_bus_pkg::TgtSram;
    end else if (soc_hit) begin
      tgt_o = croc_bus_pkg::TgtSocCtrl;
    end else if (gpio_hit) begin
      tgt_o = croc_bus_pkg::TgtGpio;
    end
  end

  // Error target has no enable of its own
  assign sram_req_o = req_i && sram_hit;
  assign soc_req_o  = req_i && soc_hit;
  assign gpio_req_o = req_i && gpio_hit;

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  // Map pages must not overlap
  one_target_a : assert final ($onehot0({sram_req_o, soc_req_o, gpio_req_o}))
    else $error("decoder enabled more than one target");

endmodule

`default_nettype wire

// File: verilog/croc_bus_pkg.sv
// Bus widths and shared types of the data-side bus.
// Modules refer to these by scoped names.
`default_nettype none

package croc_bus_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned BeWidth      = DataWidth / 8;

  // Address word split into 4 KiB page, word and byte lane
  localparam int unsigned PageWidth    = 20;
  localparam int unsigned WordIdxWidth = 10;
  localparam int unsigned LaneWidth    = 2;

  // ------------------------------------------------------------
  // Address word
  // ------------------------------------------------------------
  typedef struct packed {
    logic [PageWidth-1:0]    page;
    logic [WordIdxWidth-1:0] word_idx;
    logic [LaneWidth-1:0]    byte_lane;
  } croc_addr_fields_t;

  // Same 32 bits as a byte address or as separate fields
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    croc_addr_fields_t    fields;
  } croc_addr_u;

  // Target selected by the address decoder
  typedef enum logic [1:0] {
    TgtSram    = 2'd0,
    TgtSocCtrl = 2'd1,
    TgtGpio    = 2'd2,
    TgtError   = 2'd3
  } croc_tgt_e;

endpackage

`default_nettype wire

// File: verilog/croc_domain.sv
// Data-side bus slice of the SoC with SRAM, control regs and GPIO.
// One external manager port, every request granted at once.
`default_nettype none
`timescale 1ns/100ps

module croc_domain #(
  parameter int unsigned BankNumWords = 256,
  parameter int unsigned GpioCount    = 16
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [croc_bus_pkg::BeWidth-1:0]   be_i,
  input  logic [croc_bus_pkg::AddrWidth-1:0] addr_i,
  input  logic [croc_bus_pkg::DataWidth-1:0] wdata_i,
  input  logic [GpioCount-1:0]               gpio_i,
  output logic                               gnt_o,
  output logic                               rvalid_o,
  output logic [croc_bus_pkg::DataWidth-1:0] rdata_o,
  output logic                               err_o,
  output logic [croc_bus_pkg::AddrWidth-1:0] boot_addr_o,
  output logic                               fetch_enable_o,
  output logic [GpioCount-1:0]               gpio_o,
  output logic [GpioCount-1:0]               gpio_out_en_o,
  output logic [GpioCount-1:0]               gpio_in_sync_o
);

  croc_bus_pkg::croc_addr_u              addr_u;
  croc_bus_pkg::croc_tgt_e               tgt;
  logic [croc_bus_pkg::WordIdxWidth-1:0] word_idx;
  logic                                  sram_req;
  logic                                  soc_req;
  logic                                  gpio_req;
  logic [croc_bus_pkg::DataWidth-1:0]    sram_rdata;
  logic [croc_bus_pkg::DataWidth-1:0]    periph_rdata;

  // No back-pressure
  assign gnt_o      = req_i;
  assign addr_u.raw = addr_i;

  // ------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------
  croc_addr_decode #(
    .BankNumWords ( BankNumWords )
  ) i_addr_decode (
    .req_i      ( req_i    ),
    .addr_i     ( addr_u   ),
    .tgt_o      ( tgt      ),
    .word_idx_o ( word_idx ),
    .sram_req_o ( sram_req ),
    .soc_req_o  ( soc_req  ),
    .gpio_req_o ( gpio_req )
  );

  // ------------------------------------------------------------
  // Execute
  // ------------------------------------------------------------
  croc_sram_bank #(
    .BankNumWords ( BankNumWords )
  ) i_sram_bank (
    .clk_i,
    .arst_n_i,
    .req_i      ( sram_req   ),
    .we_i,
    .be_i,
    .word_idx_i ( word_idx   ),
    .wdata_i,
    .rdata_o    ( sram_rdata )
  );

  croc_periph_regs #(
    .GpioCount ( GpioCount )
  ) i_periph_regs (
    .clk_i,
    .arst_n_i,
    .soc_req_i  ( soc_req      ),
    .gpio_req_i ( gpio_req     ),
    .we_i,
    .word_idx_i ( word_idx     ),
    .wdata_i,
    .gpio_i,
    .rdata_o    ( periph_rdata ),
    .boot_addr_o,
    .fetch_enable_o,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o
  );

  // ------------------------------------------------------------
  // Result
  // ------------------------------------------------------------
  croc_rsp_mux i_rsp_mux (
    .clk_i,
    .arst_n_i,
    .req_i,
    .tgt_i          ( tgt          ),
    .sram_rdata_i   ( sram_rdata   ),
    .periph_rdata_i ( periph_rdata ),
    .rvalid_o,
    .err_o,
    .rdata_o
  );

endmodule

`default_nettype wire

// File: verilog/croc_map_pkg.sv
// Address map, register word indices and reset values.
// Shared by the decoder and the targets.
`default_nettype none

package croc_map_pkg;

  // ------------------------------------------------------------
  // Target pages (address bits 31:12)
  // ------------------------------------------------------------
  localparam logic [croc_bus_pkg::PageWidth-1:0] SramPage    = 20'h10000;
  localparam logic [croc_bus_pkg::PageWidth-1:0] SocCtrlPage = 20'h03000;
  localparam logic [croc_bus_pkg::PageWidth-1:0] GpioPage    = 20'h03005;

  // ------------------------------------------------------------
  // Register word indices
  // ------------------------------------------------------------
  // SoC control
  localparam logic [croc_bus_pkg::WordIdxWidth-1:0] RegBootAddr = 10'd0;
  localparam logic [croc_bus_pkg::WordIdxWidth-1:0] RegFetchEn  = 10'd1;

  // GPIO
  localparam logic [croc_bus_pkg::WordIdxWidth-1:0] RegGpioDir  = 10'd0;
  localparam logic [croc_bus_pkg::WordIdxWidth-1:0] RegGpioOut  = 10'd1;
  localparam logic [croc_bus_pkg::WordIdxWidth-1:0] RegGpioIn   = 10'd2;

  // ------------------------------------------------------------
  // Values
  // ------------------------------------------------------------
  // Core boots from the start of SRAM
  localparam logic [croc_bus_pkg::AddrWidth-1:0] BootAddrDefault = 32'h1000_0000;

  // Read data of an access that hits no target
  localparam logic [croc_bus_pkg::DataWidth-1:0] ErrRspData = 32'hBADC_AB1E;

endpackage

`default_nettype wire

// File: verilog/croc_periph_regs.sv
// SoC control and GPIO registers behind the data bus.
// Full-word accesses only, read data one cycle after the request.
`default_nettype none
`timescale 1ns/100ps

module croc_periph_regs #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  soc_req_i,
  input  logic                                  gpio_req_i,
  input  logic                                  we_i,
  input  logic [croc_bus_pkg::WordIdxWidth-1:0] word_idx_i,
  input  logic [croc_bus_pkg::DataWidth-1:0]    wdata_i,
  input  logic [GpioCount-1:0]                  gpio_i,
  output logic [croc_bus_pkg::DataWidth-1:0]    rdata_o,
  output logic [croc_bus_pkg::AddrWidth-1:0]    boot_addr_o,
  output logic                                  fetch_enable_o,
  output logic [GpioCount-1:0]                  gpio_o,
  output logic [GpioCount-1:0]                  gpio_out_en_o,
  output logic [GpioCount-1:0]                  gpio_in_sync_o
);

  logic [croc_bus_pkg::AddrWidth-1:0] boot_addr_q;
  logic                               fetch_en_q;
  logic [GpioCount-1:0]               gpio_dir_q;
  logic [GpioCount-1:0]               gpio_out_q;
  logic [GpioCount-1:0]               gpio_meta_q;
  logic [GpioCount-1:0]               gpio_sync_q;
  logic [croc_bus_pkg::DataWidth-1:0] rdata_d;
  logic [croc_bus_pkg::DataWidth-1:0] rdata_q;

  // ------------------------------------------------------------
  // Register writes
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      boot_addr_q <= croc_map_pkg::BootAddrDefault;
      fetch_en_q  <= 1'b0;
      gpio_dir_q  <= '0;
      gpio_out_q  <= '0;
    end else if (we_i) begin
      if (soc_req_i && (word_idx_i == croc_map_pkg::RegBootAddr)) begin
        boot_addr_q <= wdata_i;
      end
      if (soc_req_i && (word_idx_i == croc_map_pkg::RegFetchEn)) begin
        fetch_en_q <= wdata_i[0];
      end
      if (gpio_req_i && (word_idx_i == croc_map_pkg::RegGpioDir)) begin
        gpio_dir_q <= wdata_i[GpioCount-1:0];
      end
      if (gpio_req_i && (word_idx_i == croc_map_pkg::RegGpioOut)) begin
        gpio_out_q <= wdata_i[GpioCount-1:0];
      end
    end
  end

  // Two-flop synchronizer on the pads
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_meta_q <= '0;
      gpio_sync_q <= '0;
    end else begin
      gpio_meta_q <= gpio_i;
      gpio_sync_q <= gpio_meta_q;
    end
  end

  // ------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------
  always_comb begin
    rdata_d = '0;
    if (soc_req_i) begin
      if (word_idx_i == croc_map_pkg::RegBootAddr) rdata_d = boot_addr_q;
      if (word_idx_i == croc_map_pkg::RegFetchEn)  rdata_d[0] = fetch_en_q;
    end else if (gpio_req_i) begin
      if (word_idx_i == croc_map_pkg::RegGpioDir) rdata_d[GpioCount-1:0] = gpio_dir_q;
      if (word_idx_i == croc_map_pkg::RegGpioOut) rdata_d[GpioCount-1:0] = gpio_out_q;
      if (word_idx_i == croc_map_pkg::RegGpioIn)  rdata_d[GpioCount-1:0] = gpio_sync_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((soc_req_i || gpio_req_i) && !we_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o        = rdata_q;
  assign boot_addr_o    = boot_addr_q;
  assign fetch_enable_o = fetch_en_q;
  assign gpio_o         = gpio_out_q;
  assign gpio_out_en_o  = gpio_dir_q;
  assign gpio_in_sync_o = gpio_sync_q;

  // Both blocks share one read register
  one_block_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) !(soc_req_i && gpio_req_i)
  ) else $error("SoC control and GPIO selected together");

endmodule

`default_nettype wire

// File: verilog/croc_rsp_mux.sv
// Response stage of the data bus.
// Tracks the accepted target and forms the response beat.
`default_nettype none
`timescale 1ns/100ps

module croc_rsp_mux (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               req_i,
  input  croc_bus_pkg::croc_tgt_e            tgt_i,
  input  logic [croc_bus_pkg::DataWidth-1:0] sram_rdata_i,
  input  logic [croc_bus_pkg::DataWidth-1:0] periph_rdata_i,
  output logic                               rvalid_o,
  output logic                               err_o,
  output logic [croc_bus_pkg::DataWidth-1:0] rdata_o
);

  logic                    rvalid_q;
  logic                    err_q;
  croc_bus_pkg::croc_tgt_e tgt_q;

  // One response per accepted request a cycle later
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      tgt_q    <= croc_bus_pkg::TgtSram;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i && (tgt_i == croc_bus_pkg::TgtError);
      if (req_i) begin
        tgt_q <= tgt_i;
      end
    end
  end

  // Error subordinate lives here
  always_comb begin
    unique case (tgt_q)
      croc_bus_pkg::TgtSram:    rdata_o = sram_rdata_i;
      croc_bus_pkg::TgtSocCtrl: rdata_o = periph_rdata_i;
      croc_bus_pkg::TgtGpio:    rdata_o = periph_rdata_i;
      default:                  rdata_o = croc_map_pkg::ErrRspData;
    endcase
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

  err_with_rvalid_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) err_o |-> rvalid_o
  ) else $error("error flag outside a response beat");

endmodule

`default_nettype wire

// File: verilog/croc_sram_bank.sv
// Single-port SRAM bank with byte-lane writes.
// Read data is ready one cycle after the request.
`default_nettype none
`timescale 1ns/100ps

module croc_sram_bank #(
  parameter int unsigned BankNumWords = 256
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  req_i,
  input  logic                                  we_i,
  input  logic [croc_bus_pkg::BeWidth-1:0]      be_i,
  input  logic [croc_bus_pkg::WordIdxWidth-1:0] word_idx_i,
  input  logic [croc_bus_pkg::DataWidth-1:0]    wdata_i,
  output logic [croc_bus_pkg::DataWidth-1:0]    rdata_o
);

  localparam int unsigned IdxWidth = (BankNumWords > 1) ? $clog2(BankNumWords) : 1;

  logic [croc_bus_pkg::DataWidth-1:0] mem_q [BankNumWords];
  logic [IdxWidth-1:0]                idx;
  logic [croc_bus_pkg::DataWidth-1:0] rdata_q;

  // Decoder keeps the index inside the bank
  assign idx = word_idx_i[IdxWidth-1:0];

  // ------------------------------------------------------------
  // Array write
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < croc_bus_pkg::BeWidth; b++) begin
        if (be_i[b]) begin
          mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read port holds the last read word during writes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign rdata_o = rdata_q;

  // Decoder must never route an out-of-bank index here
  idx_in_bank_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    req_i |-> (32'(word_idx_i) < BankNumWords)
  ) else $error("SRAM access beyond bank size");

endmodule

`default_nettype wire
